/* logic/fp_pkg.sv */
package fp_pkg;

    // binary32 word: sign, 8-bit exponent, 23-bit fraction
    typedef logic [31:0] fp_word_t;

    typedef logic [7:0] exp_t;

    // signed working exponent with headroom for overflow and underflow
    typedef logic signed [9:0] exp_ext_t;

    typedef logic [22:0] frc_t;

    // exact product of two 24-bit significands
    typedef logic [47:0] man_full_t;

    // hidden bit at 26, fraction 25..3, guard 2, round 1, sticky 0
    typedef logic [26:0] man_norm_t;

    localparam exp_ext_t EXP_BIAS = 10'sd127;
    localparam exp_ext_t EXP_MAX  = 10'sd255;

    // default quiet NaN
    localparam fp_word_t QNAN = 32'h7FC0_0000;

endpackage

/* logic/fp_round_pkg.sv */
package fp_round_pkg;

    // unused codes 101..111 fall back to nearest even
    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } round_mode_t;

endpackage

/* logic/fp_mul_unpack.sv */
`timescale 1ns/1ps

module fp_mul_unpack (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  fp_pkg::fp_word_t          fp_X,
    input  fp_pkg::fp_word_t          fp_Y,
    input  fp_round_pkg::round_mode_t r_mode_in,
    output logic                      s1_valid,
    output fp_pkg::fp_word_t          op_X,
    output fp_pkg::fp_word_t          op_Y,
    output fp_round_pkg::round_mode_t r_mode,
    output fp_pkg::frc_t              frc_X,
    output fp_pkg::frc_t              frc_Y,
    output logic                      sign_Z,
    output fp_pkg::exp_ext_t          exp_sum,
    output logic                      x_sub,
    output logic                      x_inf,
    output logic                      x_zero,
    output logic                      x_nan,
    output logic                      y_sub,
    output logic                      y_inf,
    output logic                      y_zero,
    output logic                      y_nan
);

    fp_pkg::exp_t exp_X;
    fp_pkg::exp_t exp_Y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // operands and mode held until the next valid pair
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_X   <= fp_X;
            op_Y   <= fp_Y;
            r_mode <= r_mode_in;
        end
    end

    assign exp_X = op_X[30:23];
    assign exp_Y = op_Y[30:23];
    assign frc_X = op_X[22:0];
    assign frc_Y = op_Y[22:0];

    assign x_sub  = (exp_X == 8'h00) && (frc_X != '0);
    assign x_zero = (exp_X == 8'h00) && (frc_X == '0);
    assign x_inf  = (exp_X == 8'hFF) && (frc_X == '0);
    assign x_nan  = (exp_X == 8'hFF) && (frc_X != '0);

    assign y_sub  = (exp_Y == 8'h00) && (frc_Y != '0);
    assign y_zero = (exp_Y == 8'h00) && (frc_Y == '0);
    assign y_inf  = (exp_Y == 8'hFF) && (frc_Y == '0);
    assign y_nan  = (exp_Y == 8'hFF) && (frc_Y != '0);

    assign sign_Z = op_X[31] ^ op_Y[31];

    // one bias too many after the add
    assign exp_sum = {2'b00, exp_X} + {2'b00, exp_Y} - fp_pkg::EXP_BIAS;

endmodule

/* logic/fp_booth_mul.sv */
`timescale 1ns/1ps

module fp_booth_mul (
    input  fp_pkg::frc_t      frc_X,
    input  fp_pkg::frc_t      frc_Y,
    output fp_pkg::man_full_t frc_Z_full
);

    logic [23:0] man_a;
    logic [26:0] b_ext;
    logic [2:0]  trip;
    logic [47:0] mag;
    logic        neg;

    // 13 digits padded to 16 for the tree
    logic [47:0] pp [16];
    logic [47:0] lvl1 [8];
    logic [47:0] lvl2 [4];
    logic [47:0] lvl3 [2];

    assign man_a = {1'b1, frc_X};
    // zero above the msb keeps the multiplier unsigned, zero below is b[-1]
    assign b_ext = {2'b00, 1'b1, frc_Y, 1'b0};

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            pp[i] = '0;
        end
        for (int i = 0; i < 13; i++) begin
            trip = b_ext[2*i+2 -: 3];
            neg  = trip[2] & ~(trip[1] & trip[0]);
            case (trip)
                3'b001, 3'b010, 3'b101, 3'b110: mag = {24'd0, man_a};
                3'b011, 3'b100:                 mag = {23'd0, man_a, 1'b0};
                default:                        mag = '0;
            endcase
            // two's complement wraps cleanly modulo 2^48
            pp[i] = (neg ? (~mag + 48'd1) : mag) << (2 * i);
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lvl1[i] = pp[2*i] + pp[2*i+1];
        end
        for (int i = 0; i < 4; i++) begin
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        end
        for (int i = 0; i < 2; i++) begin
            lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
        end
    end

    assign frc_Z_full = lvl3[0] + lvl3[1];

endmodule

/* logic/fp_mul_norm.sv */
`timescale 1ns/1ps

module fp_mul_norm (
    input  fp_pkg::man_full_t frc_Z_full,
    input  fp_pkg::exp_ext_t  exp_sum,
    output fp_pkg::man_norm_t frc_Z_norm,
    output logic              norm_n,
    output fp_pkg::exp_ext_t  exp_norm
);

    logic [25:0] kept;
    logic        sticky;

    assign norm_n = frc_Z_full[47];

    // product lies in [1,4); msb set means [2,4)
    always_comb begin
        if (norm_n) begin
            kept     = frc_Z_full[47:22];
            sticky   = |frc_Z_full[21:0];
            exp_norm = exp_sum + 10'sd1;
        end else begin
            kept     = frc_Z_full[46:21];
            sticky   = |frc_Z_full[20:0];
            exp_norm = exp_sum;
        end
    end

    assign frc_Z_norm = {kept, sticky};

endmodule

/* logic/fp_mul_round.sv */
`timescale 1ns/1ps

module fp_mul_round (
    input  fp_pkg::man_norm_t         frc_Z_norm,
    input  fp_pkg::exp_ext_t          exp_norm,
    input  logic                      sign_Z,
    input  fp_round_pkg::round_mode_t r_mode,
    output fp_pkg::frc_t              frc_Z,
    output logic                      norm_r,
    output fp_pkg::exp_ext_t          exp_final
);

    fp_pkg::frc_t frac;
    logic         guard_b;
    logic         round_b;
    logic         sticky_b;
    logic         inexact;
    logic         inc;
    logic [23:0]  sum;

    assign frac     = frc_Z_norm[25:3];
    assign guard_b  = frc_Z_norm[2];
    assign round_b  = frc_Z_norm[1];
    assign sticky_b = frc_Z_norm[0];
    assign inexact  = guard_b | round_b | sticky_b;

    always_comb begin
        case (r_mode)
            fp_round_pkg::RTZ: inc = 1'b0;
            fp_round_pkg::RDN: inc = sign_Z & inexact;
            fp_round_pkg::RUP: inc = ~sign_Z & inexact;
            fp_round_pkg::RMM: inc = guard_b;
            // nearest even, also for the unused codes
            default:           inc = guard_b & (round_b | sticky_b | frac[0]);
        endcase
    end

    assign sum = {1'b0, frac} + {23'd0, inc};

    // all-ones fraction rolls over to 1.0 of the next binade
    assign norm_r    = sum[23];
    assign frc_Z     = sum[22:0];
    assign exp_final = exp_norm + {9'd0, norm_r};

endmodule

/* logic/fp_mul_pack.sv */
`timescale 1ns/1ps

module fp_mul_pack (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              s1_valid,
    input  logic              sign_Z,
    input  fp_pkg::exp_ext_t  exp_final,
    input  fp_pkg::frc_t      frc_Z,
    input  logic              x_sub,
    input  logic              x_inf,
    input  logic              x_zero,
    input  logic              x_nan,
    input  logic              y_sub,
    input  logic              y_inf,
    input  logic              y_zero,
    input  logic              y_nan,
    output fp_pkg::fp_word_t  fp_Z_comb,
    output logic              ovrf_comb,
    output logic              udrf_comb,
    output fp_pkg::fp_word_t  fp_Z,
    output logic              out_valid,
    output logic              ovrf,
    output logic              udrf
);

    logic         x_low;
    logic         y_low;
    logic         bad_op;
    fp_pkg::exp_t exp_field;

    // subnormals count as zero
    assign x_low  = x_zero | x_sub;
    assign y_low  = y_zero | y_sub;
    assign bad_op = x_nan | y_nan | (x_inf & y_low) | (y_inf & x_low);

    assign exp_field = exp_final[7:0];

    always_comb begin
        ovrf_comb = 1'b0;
        udrf_comb = 1'b0;
        if (bad_op) begin
            fp_Z_comb = fp_pkg::QNAN;
        end else if (x_inf | y_inf) begin
            fp_Z_comb = {sign_Z, 8'hFF, 23'd0};
        end else if (x_low | y_low) begin
            fp_Z_comb = {sign_Z, 31'd0};
        end else if (exp_final >= fp_pkg::EXP_MAX) begin
            fp_Z_comb = {sign_Z, 8'hFF, 23'd0};
            ovrf_comb = 1'b1;
        end else if (exp_final <= 10'sd0) begin
            fp_Z_comb = {sign_Z, 31'd0};
            udrf_comb = 1'b1;
        end else begin
            fp_Z_comb = {sign_Z, exp_field, frc_Z};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ovrf      <= 1'b0;
            udrf      <= 1'b0;
            fp_Z      <= '0;
        end else begin
            out_valid <= s1_valid;
            ovrf      <= s1_valid & ovrf_comb;
            udrf      <= s1_valid & udrf_comb;
            if (s1_valid) begin
                fp_Z <= fp_Z_comb;
            end
        end
    end

    // results are flushed, so a zero exponent field means a signed zero
    no_subnormal_out: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && (fp_Z[30:23] == 8'h00)) |-> (fp_Z[22:0] == '0));

    // all-ones exponent only for infinity or the quiet NaN
    top_exp_special: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && (fp_Z[30:23] == 8'hFF))
        |-> ((fp_Z[22:0] == '0) || (fp_Z == fp_pkg::QNAN)));

endmodule

/* logic/fp_mul_checker.sv */
`timescale 1ns/1ps

module fp_mul_checker (
    input  fp_pkg::fp_word_t          fp_X,
    input  fp_pkg::fp_word_t          fp_Y,
    input  fp_pkg::fp_word_t          fp_Z,
    input  fp_round_pkg::round_mode_t r_mode,
    input  logic                      ovrf,
    input  logic                      udrf,
    input  fp_pkg::man_full_t         frc_Z_full,
    input  fp_pkg::frc_t              frc_X,
    input  fp_pkg::frc_t              frc_Y,
    input  fp_pkg::man_norm_t         frc_Z_norm,
    input  logic                      norm_n,
    input  logic                      sign_Z,
    input  logic                      norm_r,
    input  fp_pkg::frc_t              frc_Z
);

    // low means exponent field zero, top means all ones
    logic x_low, x_top, x_nan;
    logic y_low, y_top, y_nan;
    logic exp_sign;

    fp_pkg::man_full_t man_ref;
    fp_pkg::man_full_t norm_ref;

    fp_pkg::frc_t frac;
    logic         guard_b;
    logic         inexact;
    fp_pkg::frc_t frac_rne;
    fp_pkg::frc_t frac_rdn;
    fp_pkg::frc_t frac_rup;
    fp_pkg::frc_t frac_rmm;
    logic [23:0]  carry;

    always_comb begin
        x_low = (fp_X[30:23] == 8'h00);
        x_top = (fp_X[30:23] == 8'hFF);
        x_nan = x_top && (fp_X[22:0] != '0);
        y_low = (fp_Y[30:23] == 8'h00);
        y_top = (fp_Y[30:23] == 8'hFF);
        y_nan = y_top && (fp_Y[22:0] != '0);
        exp_sign = fp_X[31] ^ fp_Y[31];

        low_gives_zero: assert (((x_low && !y_top) || (y_low && !x_top)) ->
                                (fp_Z == {exp_sign, 31'd0}));

        nan_gives_qnan: assert ((x_nan || y_nan || (x_top && y_low) || (y_top && x_low)) ->
                                (fp_Z == fp_pkg::QNAN));

        // booth tree against a plain multiply
        man_ref = {1'b1, frc_X} * {1'b1, frc_Y};
        booth_exact: assert (frc_Z_full == man_ref);

        norm_ref = frc_Z_full[47] ? frc_Z_full : {frc_Z_full[46:0], 1'b0};
        norm_shift: assert ((frc_Z_norm[26:1] == norm_ref[47:22])
                            && (frc_Z_norm[0] == |norm_ref[21:0])
                            && (norm_n == frc_Z_full[47]));

        norm_hidden_bit: assert ((!x_low && !x_top && !y_low && !y_top) -> frc_Z_norm[26]);

        round_sign: assert (sign_Z == exp_sign);

        frac     = frc_Z_norm[25:3];
        guard_b  = frc_Z_norm[2];
        inexact  = |frc_Z_norm[2:0];
        frac_rne = frac + {22'd0, guard_b & (|frc_Z_norm[1:0] | frac[0])};
        frac_rdn = frac + {22'd0, sign_Z & inexact};
        frac_rup = frac + {22'd0, !sign_Z & inexact};
        frac_rmm = frac + {22'd0, guard_b};

        round_rne: assert (!(r_mode inside {fp_round_pkg::RTZ, fp_round_pkg::RDN,
                                            fp_round_pkg::RUP, fp_round_pkg::RMM})
                           -> (frc_Z == frac_rne));

        round_rtz: assert ((r_mode == fp_round_pkg::RTZ) -> (frc_Z == frac));

        round_rdn: assert ((r_mode == fp_round_pkg::RDN) -> (frc_Z == frac_rdn));

        round_rup: assert ((r_mode == fp_round_pkg::RUP) -> (frc_Z == frac_rup));

        round_rmm: assert ((r_mode == fp_round_pkg::RMM) -> (frc_Z == frac_rmm));

        // carry only possible from an all-ones fraction
        carry = {1'b0, frac} + 24'd1;
        round_carry: assert (norm_r -> (carry[23] && (frc_Z == '0)));

        ovrf_gives_inf: assert (ovrf -> (fp_Z == {sign_Z, 8'hFF, 23'd0}) && !udrf);

        udrf_gives_zero: assert (udrf -> (fp_Z == {sign_Z, 31'd0}));

        three_times_three: assert ((fp_X == 32'h4040_0000 && fp_Y == 32'h4040_0000
                                    && r_mode == fp_round_pkg::RTZ)
                                   -> (fp_Z == 32'h4110_0000));
    end

endmodule

/* logic/fp_mul_top.sv */
`timescale 1ns/1ps

module fp_mul_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  fp_pkg::fp_word_t          fp_X,
    input  fp_pkg::fp_word_t          fp_Y,
    input  fp_round_pkg::round_mode_t r_mode,
    output logic                      out_valid,
    output fp_pkg::fp_word_t          fp_Z,
    output logic                      ovrf,
    output logic                      udrf
);

    // first stage outputs
    logic                      s1_valid;
    fp_pkg::fp_word_t          op_X;
    fp_pkg::fp_word_t          op_Y;
    fp_round_pkg::round_mode_t s1_r_mode;
    fp_pkg::frc_t              frc_X;
    fp_pkg::frc_t              frc_Y;
    logic                      sign_Z;
    fp_pkg::exp_ext_t          exp_sum;
    logic                      x_sub, x_inf, x_zero, x_nan;
    logic                      y_sub, y_inf, y_zero, y_nan;

    // combinational core
    fp_pkg::man_full_t         frc_Z_full;
    fp_pkg::man_norm_t         frc_Z_norm;
    logic                      norm_n;
    fp_pkg::exp_ext_t          exp_norm;
    fp_pkg::frc_t              frc_Z;
    logic                      norm_r;
    fp_pkg::exp_ext_t          exp_final;

    fp_pkg::fp_word_t          fp_Z_comb;
    logic                      ovrf_comb;
    logic                      udrf_comb;

    fp_mul_unpack u_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .fp_X     (fp_X),
        .fp_Y     (fp_Y),
        .r_mode_in(r_mode),
        .s1_valid (s1_valid),
        .op_X     (op_X),
        .op_Y     (op_Y),
        .r_mode   (s1_r_mode),
        .frc_X    (frc_X),
        .frc_Y    (frc_Y),
        .sign_Z   (sign_Z),
        .exp_sum  (exp_sum),
        .x_sub    (x_sub),
        .x_inf    (x_inf),
        .x_zero   (x_zero),
        .x_nan    (x_nan),
        .y_sub    (y_sub),
        .y_inf    (y_inf),
        .y_zero   (y_zero),
        .y_nan    (y_nan)
    );

    fp_booth_mul u_booth (
        .frc_X     (frc_X),
        .frc_Y     (frc_Y),
        .frc_Z_full(frc_Z_full)
    );

    fp_mul_norm u_norm (
        .frc_Z_full(frc_Z_full),
        .exp_sum   (exp_sum),
        .frc_Z_norm(frc_Z_norm),
        .norm_n    (norm_n),
        .exp_norm  (exp_norm)
    );

    fp_mul_round u_round (
        .frc_Z_norm(frc_Z_norm),
        .exp_norm  (exp_norm),
        .sign_Z    (sign_Z),
        .r_mode    (s1_r_mode),
        .frc_Z     (frc_Z),
        .norm_r    (norm_r),
        .exp_final (exp_final)
    );

    fp_mul_pack u_pack (
        .clk      (clk),
        .rst_n    (rst_n),
        .s1_valid (s1_valid),
        .sign_Z   (sign_Z),
        .exp_final(exp_final),
        .frc_Z    (frc_Z),
        .x_sub    (x_sub),
        .x_inf    (x_inf),
        .x_zero   (x_zero),
        .x_nan    (x_nan),
        .y_sub    (y_sub),
        .y_inf    (y_inf),
        .y_zero   (y_zero),
        .y_nan    (y_nan),
        .fp_Z_comb(fp_Z_comb),
        .ovrf_comb(ovrf_comb),
        .udrf_comb(udrf_comb),
        .fp_Z     (fp_Z),
        .out_valid(out_valid),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

    // checker sees one item, all taken before the output register
    fp_mul_checker u_checker (
        .fp_X      (op_X),
        .fp_Y      (op_Y),
        .fp_Z      (fp_Z_comb),
        .r_mode    (s1_r_mode),
        .ovrf      (ovrf_comb),
        .udrf      (udrf_comb),
        .frc_Z_full(frc_Z_full),
        .frc_X     (frc_X),
        .frc_Y     (frc_Y),
        .frc_Z_norm(frc_Z_norm),
        .norm_n    (norm_n),
        .sign_Z    (sign_Z),
        .norm_r    (norm_r),
        .frc_Z     (frc_Z)
    );

endmodule

/* dv/fp_mul_tb.sv */
`timescale 1ns/1ps

module fp_mul_tb;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    fp_pkg::fp_word_t          fp_X;
    fp_pkg::fp_word_t          fp_Y;
    fp_round_pkg::round_mode_t r_mode;
    logic                      out_valid;
    fp_pkg::fp_word_t          fp_Z;
    logic                      ovrf;
    logic                      udrf;

    // vectors as read from the file
    fp_pkg::fp_word_t vec_x[$];
    fp_pkg::fp_word_t vec_y[$];
    logic [2:0]       vec_mode[$];
    fp_pkg::fp_word_t exp_z[$];
    logic             exp_ovrf[$];
    logic             exp_udrf[$];

    // items in flight, oldest first
    int pend_idx[$];
    int pend_cycle[$];

    int cycle_count = 0;
    int limit = 0;
    int nvec = 0;
    int value_errors = 0;
    int other_errors = 0;
    int mon_idx;
    int mon_issued;

    fp_mul_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .fp_X     (fp_X),
        .fp_Y     (fp_Y),
        .r_mode   (r_mode),
        .out_valid(out_valid),
        .fp_Z     (fp_Z),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_word(input string name, input fp_pkg::fp_word_t got,
                              input fp_pkg::fp_word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a, b, m, z, o, u;
        fd = $fopen("dv/fp_mul_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file dv/fp_mul_stimulus.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // skip blank and comment lines
                if (line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h %h", a, b, m, z, o, u);
                    if (n == 6) begin
                        vec_x.push_back(a);
                        vec_y.push_back(b);
                        vec_mode.push_back(m[2:0]);
                        exp_z.push_back(z);
                        exp_ovrf.push_back(o[0]);
                        exp_udrf.push_back(u[0]);
                    end else begin
                        $display("malformed vector line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d value, %0d other", value_errors, other_errors);
    endtask

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (pend_idx.size() == 0) begin
                $display("out_valid high with no vector outstanding at cycle %0d",
                         cycle_count);
                other_errors++;
            end else begin
                mon_idx    = pend_idx.pop_front();
                mon_issued = pend_cycle.pop_front();
                if (cycle_count - mon_issued != 2) begin
                    $display("vector %0d came out %0d cycles after in_valid, two expected",
                             mon_idx, cycle_count - mon_issued);
                    other_errors++;
                end
                check_word("fp_Z", fp_Z, exp_z[mon_idx]);
                check_flag("ovrf", ovrf, exp_ovrf[mon_idx]);
                check_flag("udrf", udrf, exp_udrf[mon_idx]);
            end
        end
    end

    initial begin
        wait (limit > 0);
        while (cycle_count < limit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles with %0d results missing",
                 cycle_count, pend_idx.size());
        report_counts();
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        fp_X     = '0;
        fp_Y     = '0;
        r_mode   = fp_round_pkg::RNE;
        load_vectors();
        nvec = vec_x.size();
        if (nvec == 0) begin
            $display("no vectors read from the vector file");
            other_errors++;
        end
        limit = 16 + nvec + 20;

        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        // reset values of the output stage
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_word("fp_Z", fp_Z, '0);
        check_flag("ovrf", ovrf, 1'b0);
        check_flag("udrf", udrf, 1'b0);

        for (int i = 0; i < nvec; i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            fp_X     = vec_x[i];
            fp_Y     = vec_y[i];
            r_mode   = fp_round_pkg::round_mode_t'(vec_mode[i]);
            pend_idx.push_back(i);
            pend_cycle.push_back(cycle_count);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        fp_X     = '0;
        fp_Y     = '0;

        while (pend_idx.size() != 0) begin
            @(negedge clk);
        end
        // stray outputs after the last vector
        repeat (3) @(negedge clk);

        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dv/fp_mul_stimulus.txt */
// fp_X fp_Y r_mode expected_fp_Z expected_ovrf expected_udrf, all hex
// r_mode 0 RNE, 1 RTZ, 2 RDN, 3 RUP, 4 RMM, 5 falls back to RNE
40400000 40400000 1 41100000 0 0
3FC00000 40000000 0 40400000 0 0
C0200000 40800000 1 C1200000 0 0
3F800001 3F800001 0 3F800002 0 0
3F800001 3F800001 3 3F800003 0 0
BF800001 3F800001 2 BF800003 0 0
BF800001 3F800001 3 BF800002 0 0
3F800001 3FC00000 0 3FC00002 0 0
3F800001 3FC00000 1 3FC00001 0 0
3F800001 3FC00000 4 3FC00002 0 0
3F800003 3FC00000 0 3FC00004 0 0
3F800003 3FC00000 4 3FC00005 0 0
3FFFFFFE 3F800001 0 40000000 0 0
BFFFFFFE 3F800001 1 BFFFFFFF 0 0
BFFFFFFE 3F800001 2 C0000000 0 0
3F800001 3FC00000 5 3FC00002 0 0
80000000 40400000 0 80000000 0 0
00000001 C0000000 0 80000000 0 0
FF800000 40400000 0 FF800000 0 0
7F800001 3F800000 0 7FC00000 0 0
7F800000 00000000 0 7FC00000 0 0
FF800000 00000010 0 7FC00000 0 0
7F000000 40000000 0 7F800000 1 0
FF000000 7F000000 0 FF800000 1 0
7F7FFFFF 3F800000 0 7F7FFFFF 0 0
00800000 3F000000 0 00000000 0 1
80800000 00800000 0 80000000 0 1
00800000 40000000 0 01000000 0 0

/* tb.f */
logic/fp_pkg.sv
logic/fp_round_pkg.sv
logic/fp_mul_unpack.sv
logic/fp_booth_mul.sv
logic/fp_mul_norm.sv
logic/fp_mul_round.sv
logic/fp_mul_pack.sv
logic/fp_mul_checker.sv
logic/fp_mul_top.sv
dv/fp_mul_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fp_mul_tb \
    -f tb.f -o fp_mul_sim

status=0
./obj_dir/fp_mul_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit "$status"
fi
grep -q "TESTS PASSED" sim.log
